/* Makefile */
.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -f all.f --top-module valu_top

sim:
	verilator --binary --timing --assert -f all.f --top-module tb_valu_top -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* all.f */
valu_cfg_pkg.sv
valu_op_pkg.sv
valu_lane.sv
valu_operand_router.sv
valu_sequencer.sv
valu_result_buffer.sv
valu_top.sv
tb_valu_top.sv

/* tb_valu_top.sv */
`timescale 1ns/1ps

module tb_valu_top;
    import valu_cfg_pkg::*;
    import valu_op_pkg::*;

    // each vector is 16 words: op, sew, lmul, lane_cfg, a0..a3, b0..b3, exp0..exp3
    localparam int words_per_vec = 16;
    localparam int mem_depth     = 1024;

    logic        valu_clk;
    logic        rst_n;
    logic        start;
    alu_op_e     op;
    sew_e        sew;
    lmul_e       lmul;
    lane_cfg_e   lane_cfg;
    vreg_group_t op_a;
    vreg_group_t op_b;
    vreg_group_t result;
    logic        busy;
    logic        done;

    logic [vlen-1:0] vec_mem [0:mem_depth-1];

    // expected result of the last accepted vector
    vreg_group_t last_exp;

    int num_vec;
    int err_cnt;
    int check_cnt;
    int cycle_cnt;
    int cycle_limit = 100;

    valu_top uut (
        .valu_clk (valu_clk),
        .rst_n    (rst_n),
        .start    (start),
        .op       (op),
        .sew      (sew),
        .lmul     (lmul),
        .lane_cfg (lane_cfg),
        .op_a     (op_a),
        .op_b     (op_b),
        .result   (result),
        .busy     (busy),
        .done     (done)
    );

    initial valu_clk = 1'b0;
    always #4 valu_clk = ~valu_clk;

    // run length guard
    always @(posedge valu_clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout, run did not end within %0d cycles", cycle_limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic compare_word(input string name, input vreg_group_t got,
                                input vreg_group_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("error at %0t ns: %s expected %0h got %0h", $time, name, exp, got);
        end
    endtask

    task automatic report_failure(input string what);
        err_cnt++;
        $display("failure at %0t ns: %s", $time, what);
    endtask

    // passes = registers over groups, rounded up
    function automatic int pass_count(input int lmul_code, input int cfg_code);
        int n_regs;
        int n_grp;
        int p;

        n_regs = 1 << lmul_code;
        n_grp  = 1 << cfg_code;
        p      = (n_regs + n_grp - 1) / n_grp;
        return (p < 1) ? 1 : p;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // one vector from the data file
    task automatic run_vector(input int v);
        int          base;
        int          passes;
        int          n;
        logic        seen;
        vreg_group_t exp_res;

        base     = v * words_per_vec;
        op       = alu_op_e'(vec_mem[base][3:0]);
        sew      = sew_e'(vec_mem[base + 1][2:0]);
        lmul     = lmul_e'(vec_mem[base + 2][2:0]);
        lane_cfg = lane_cfg_e'(vec_mem[base + 3][1:0]);
        for (int r = 0; r < max_regs; r++) begin
            op_a[r]    = vec_mem[base + 4 + r];
            op_b[r]    = vec_mem[base + 8 + r];
            exp_res[r] = vec_mem[base + 12 + r];
        end
        last_exp = exp_res;
        passes   = pass_count(int'(lmul), int'(lane_cfg));
        start    = 1'b1;

        // start edge
        @(posedge valu_clk);
        #1;
        compare_word("busy after start", busy, 1);

        // a second start while busy, must be dropped
        op   = op_sub;
        op_a = '1;

        n    = 0;
        seen = 1'b0;
        while (!seen && n < 16) begin
            @(posedge valu_clk);
            #1;
            n++;
            start = 1'b0;
            if (done) begin
                seen = 1'b1;
            end else if (busy !== 1'b1) begin
                report_failure($sformatf("busy dropped before done in vector %0d", v));
            end
        end

        if (!seen) begin
            report_failure($sformatf("done never rose for vector %0d", v));
        end else begin
            compare_word("done latency", n, passes + 1);
            for (int r = 0; r < max_regs; r++) begin
                compare_word($sformatf("result[%0d] vector %0d", r, v), result[r], exp_res[r]);
            end
            @(posedge valu_clk);
            #1;
            compare_word("done after pulse", done, 0);
            compare_word("result held", result, exp_res);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // illegal command must leave the DUT untouched
    task automatic apply_illegal(input string what, input alu_op_e o, input sew_e s,
                                 input lane_cfg_e c);
        op       = o;
        sew      = s;
        lmul     = lmul_1;
        lane_cfg = c;
        start    = 1'b1;
        @(posedge valu_clk);
        #1;
        start = 1'b0;
        repeat (6) begin
            if (busy !== 1'b0 || done !== 1'b0) begin
                report_failure($sformatf("%s started the DUT", what));
            end
            @(posedge valu_clk);
            #1;
        end
        compare_word($sformatf("result after %s", what), result, last_exp);
    endtask

    initial begin
        rst_n     = 1'b0;
        start     = 1'b0;
        op        = op_idle;
        sew       = sew_8;
        lmul      = lmul_1;
        lane_cfg  = lanes_1;
        op_a      = '0;
        op_b      = '0;
        last_exp  = '0;
        err_cnt   = 0;
        check_cnt = 0;
        cycle_cnt = 0;
        void'($urandom(39505));

        $readmemh("valu_testdata.txt", vec_mem);
        num_vec = 0;
        while ((num_vec + 1) * words_per_vec <= mem_depth &&
               !$isunknown(vec_mem[num_vec * words_per_vec])) begin
            num_vec++;
        end
        if (num_vec == 0) begin
            report_failure("no vectors read from valu_testdata.txt");
        end
        cycle_limit = 8 * num_vec + 100;

        repeat (8) @(posedge valu_clk);
        #1;
        rst_n = 1'b1;
        compare_word("busy after reset", busy, 0);
        compare_word("done after reset", done, 0);
        compare_word("result after reset", result, '0);

        for (int v = 0; v < num_vec; v++) begin
            run_vector(v);
            repeat ($urandom % 4) begin
                @(posedge valu_clk);
                #1;
            end
        end

        apply_illegal("opcode 13", alu_op_e'(4'd13), sew_8, lanes_1);
        apply_illegal("sew 3", op_add, sew_e'(3'd3), lanes_1);
        apply_illegal("lane config 3", op_add, sew_8, lane_cfg_e'(2'd3));

        $display("checks %0d, errors %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* valu_cfg_pkg.sv */
package valu_cfg_pkg;

    // register and lane geometry
    localparam int vlen            = 128;
    localparam int elen            = 32;
    localparam int lanes_per_group = 4;
    localparam int max_groups      = 4;

    // a register group spans up to four registers
    localparam int max_regs = 4;

    // pass counter and register index widths
    localparam int pass_w    = 2;
    localparam int reg_idx_w = $clog2(max_regs);

    // one vector register
    typedef logic [vlen-1:0] vreg_t;

    // register group, register 0 in the low 128 bits
    typedef vreg_t [max_regs-1:0] vreg_group_t;

    typedef logic [elen-1:0] lane_word_t;

    // register index inside a group
    typedef logic [reg_idx_w-1:0] reg_idx_t;

endpackage

/* valu_lane.sv */
`timescale 1ns/1ps

module valu_lane (
    input  valu_op_pkg::alu_op_e     op,
    input  valu_op_pkg::sew_e        sew,
    input  valu_cfg_pkg::lane_word_t a,
    input  valu_cfg_pkg::lane_word_t b,
    output valu_cfg_pkg::lane_word_t y
);
    import valu_cfg_pkg::*;
    import valu_op_pkg::*;

    // most elements in one word, at sew 8
    localparam int max_elem = elen / 8;

    int         ew;
    int         n_elem;
    lane_word_t emask;

    //////////////////////////////////////////////////////////////////////
    // element operation
    // operands arrive right-aligned and zero-extended, result is masked
    function automatic lane_word_t elem_op(
        alu_op_e    f_op,
        lane_word_t ea,
        lane_word_t eb,
        lane_word_t mask,
        int         width
    );
        lane_word_t sa;
        lane_word_t sb;
        lane_word_t sh;
        lane_word_t r;

        // sign-extended copies for signed compare and sra
        sa = ea[width-1] ? (ea | ~mask) : ea;
        sb = eb[width-1] ? (eb | ~mask) : eb;
        // shift amount from the low log2(sew) bits of b
        sh = eb & lane_word_t'(width - 1);

        case (f_op)
            op_add:  r = ea + eb;
            op_sub:  r = ea - eb;
            op_and:  r = ea & eb;
            op_or:   r = ea | eb;
            op_xor:  r = ea ^ eb;
            op_sll:  r = ea << sh[4:0];
            op_srl:  r = ea >> sh[4:0];
            op_sra:  r = lane_word_t'($signed(sa) >>> sh[4:0]);
            op_min:  r = ($signed(sa) < $signed(sb)) ? ea : eb;
            op_max:  r = ($signed(sa) > $signed(sb)) ? ea : eb;
            op_minu: r = (ea < eb) ? ea : eb;
            op_maxu: r = (ea > eb) ? ea : eb;
            default: r = '0;
        endcase

        // wrap within the element
        return r & mask;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // element geometry for the current sew
    always_comb begin
        case (sew)
            sew_8: begin
                ew     = 8;
                n_elem = 4;
                emask  = 32'h0000_00ff;
            end
            sew_16: begin
                ew     = 16;
                n_elem = 2;
                emask  = 32'h0000_ffff;
            end
            default: begin
                ew     = 32;
                n_elem = 1;
                emask  = 32'hffff_ffff;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // split, operate, merge
    always_comb begin
        lane_word_t ea;
        lane_word_t eb;

        y = '0;
        for (int e = 0; e < max_elem; e++) begin
            ea = (a >> (e * ew)) & emask;
            eb = (b >> (e * ew)) & emask;
            if (e < n_elem) begin
                y = y | (elem_op(op, ea, eb, emask, ew) << (e * ew));
            end
        end
    end

endmodule

/* valu_op_pkg.sv */
package valu_op_pkg;

    // ALU opcodes, 13 to 15 are not legal
    typedef enum logic [3:0] {
        op_idle = 4'd0,
        op_add  = 4'd1,
        op_sub  = 4'd2,
        op_and  = 4'd3,
        op_or   = 4'd4,
        op_xor  = 4'd5,
        op_sll  = 4'd6,
        op_srl  = 4'd7,
        op_sra  = 4'd8,
        op_min  = 4'd9,
        op_max  = 4'd10,
        op_minu = 4'd11,
        op_maxu = 4'd12
    } alu_op_e;

    // element width
    typedef enum logic [2:0] {sew_8 = 3'd0, sew_16 = 3'd1, sew_32 = 3'd2} sew_e;

    // registers per group, 1/2/4
    typedef enum logic [2:0] {lmul_1 = 3'd0, lmul_2 = 3'd1, lmul_4 = 3'd2} lmul_e;

    // enabled lane groups, 1/2/4
    typedef enum logic [1:0] {lanes_1 = 2'd0, lanes_2 = 2'd1, lanes_4 = 2'd2} lane_cfg_e;

    typedef enum logic [1:0] {
        st_idle   = 2'd0,
        st_run    = 2'd1,
        st_finish = 2'd2
    } seq_state_e;

endpackage

/* valu_operand_router.sv */
`timescale 1ns/1ps

module valu_operand_router (
    input  logic [valu_cfg_pkg::pass_w-1:0]                       pass_idx,
    input  valu_op_pkg::lane_cfg_e                                group_cnt,
    input  valu_op_pkg::lmul_e                                    reg_cnt,
    input  valu_cfg_pkg::vreg_group_t                             op_a,
    input  valu_cfg_pkg::vreg_group_t                             op_b,
    output valu_cfg_pkg::vreg_t [valu_cfg_pkg::max_groups-1:0]    grp_a,
    output valu_cfg_pkg::vreg_t [valu_cfg_pkg::max_groups-1:0]    grp_b,
    output logic [valu_cfg_pkg::max_groups-1:0]                   grp_en,
    output valu_cfg_pkg::reg_idx_t [valu_cfg_pkg::max_groups-1:0] grp_reg
);
    import valu_cfg_pkg::*;

    int n_groups;
    int n_regs;

    assign n_groups = 1 << group_cnt;
    assign n_regs   = 1 << reg_cnt;

    // group g takes register pass_idx * n_groups + g
    for (genvar g = 0; g < max_groups; g++) begin : g_map
        int reg_sel;

        assign reg_sel    = (int'(pass_idx) * n_groups) + g;
        assign grp_en[g]  = (g < n_groups) && (reg_sel < n_regs);
        assign grp_reg[g] = reg_idx_t'(reg_sel);
        assign grp_a[g]   = op_a[grp_reg[g]];
        assign grp_b[g]   = op_b[grp_reg[g]];
    end

    // no two enabled groups may write the same result register
    always_comb begin
        for (int i = 0; i < max_groups; i++) begin
            for (int j = i + 1; j < max_groups; j++) begin
                assert (!(grp_en[i] && grp_en[j] && (grp_reg[i] == grp_reg[j])))
                    else $error("groups %0d and %0d target one register", i, j);
            end
        end
    end

endmodule

/* valu_result_buffer.sv */
`timescale 1ns/1ps

module valu_result_buffer (
    input  logic                                                  valu_clk,
    input  logic                                                  rst_n,
    input  logic                                                  clear,
    input  logic                                                  finish,
    input  logic                                                  pass_valid,
    input  valu_cfg_pkg::vreg_t [valu_cfg_pkg::max_groups-1:0]    grp_y,
    input  logic [valu_cfg_pkg::max_groups-1:0]                   grp_en,
    input  valu_cfg_pkg::reg_idx_t [valu_cfg_pkg::max_groups-1:0] grp_reg,
    output valu_cfg_pkg::vreg_group_t                             result,
    output logic                                                  done
);
    import valu_cfg_pkg::*;

    //////////////////////////////////////////////////////////////////////
    // result registers
    // registers outside the group keep the zero from clear
    always_ff @(posedge valu_clk) begin
        if (!rst_n) begin
            result <= '0;
        end else if (clear) begin
            result <= '0;
        end else if (pass_valid) begin
            for (int g = 0; g < max_groups; g++) begin
                if (grp_en[g]) begin
                    result[grp_reg[g]] <= grp_y[g];
                end
            end
        end
    end

    // done one edge after the finish state
    always_ff @(posedge valu_clk) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= finish;
        end
    end

    a_done_pulse: assert property (@(posedge valu_clk) disable iff (!rst_n)
        done |=> !done);

endmodule

/* valu_sequencer.sv */
`timescale 1ns/1ps

module valu_sequencer (
    input  logic                              valu_clk,
    input  logic                              rst_n,
    input  logic                              start,
    input  valu_op_pkg::alu_op_e              op,
    input  valu_op_pkg::sew_e                 sew,
    input  valu_op_pkg::lmul_e                lmul,
    input  valu_op_pkg::lane_cfg_e            lane_cfg,
    input  valu_cfg_pkg::vreg_group_t         op_a,
    input  valu_cfg_pkg::vreg_group_t         op_b,
    output valu_op_pkg::alu_op_e              cmd_op,
    output valu_op_pkg::sew_e                 cmd_sew,
    output valu_op_pkg::lmul_e                cmd_lmul,
    output valu_op_pkg::lane_cfg_e            cmd_lane_cfg,
    output valu_cfg_pkg::vreg_group_t         cmd_a,
    output valu_cfg_pkg::vreg_group_t         cmd_b,
    output logic [valu_cfg_pkg::pass_w-1:0]   pass_idx,
    output logic                              pass_valid,
    output logic                              clear,
    output logic                              finish,
    output logic                              busy
);
    import valu_cfg_pkg::*;
    import valu_op_pkg::*;

    seq_state_e          state;
    logic                cmd_legal;
    logic [pass_w-1:0]   last_pass;

    // illegal opcode, sew, lmul or lane config drops the start
    assign cmd_legal = (op <= op_maxu) && (sew <= sew_32) && (lmul <= lmul_4) &&
                       (lane_cfg <= lanes_4);

    assign clear      = start && (state == st_idle) && cmd_legal;
    assign pass_valid = (state == st_run);
    assign finish     = (state == st_finish);
    assign busy       = (state != st_idle);

    // passes = regs / groups rounded up, so last pass is that minus one
    always_comb begin
        if (cmd_lmul > cmd_lane_cfg) begin
            last_pass = pass_w'((1 << (cmd_lmul - cmd_lane_cfg)) - 1);
        end else begin
            last_pass = '0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // FSM and pass counter
    always_ff @(posedge valu_clk) begin
        if (!rst_n) begin
            state        <= st_idle;
            pass_idx     <= '0;
            cmd_op       <= op_idle;
            cmd_sew      <= sew_8;
            cmd_lmul     <= lmul_1;
            cmd_lane_cfg <= lanes_1;
        end else begin
            case (state)
                st_idle: begin
                    if (clear) begin
                        state        <= st_run;
                        pass_idx     <= '0;
                        cmd_op       <= op;
                        cmd_sew      <= sew;
                        cmd_lmul     <= lmul;
                        cmd_lane_cfg <= lane_cfg;
                    end
                end
                st_run: begin
                    if (pass_idx == last_pass) begin
                        state <= st_finish;
                    end else begin
                        pass_idx <= pass_idx + 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // operand capture
    always_ff @(posedge valu_clk) begin
        if (clear) begin
            cmd_a <= op_a;
            cmd_b <= op_b;
        end
    end

    // an idle cycle without acceptance must not start a pass
    a_no_pass_in_idle: assert property (@(posedge valu_clk) disable iff (!rst_n)
        ((state == st_idle) && !clear) |=> !pass_valid);

    // busy only drops out of the finish state, not from a pass
    a_busy_fall: assert property (@(posedge valu_clk) disable iff (!rst_n)
        ($fell(busy) && $past(rst_n)) |-> $past(finish));

endmodule

/* valu_testdata.txt */
// op sew lmul lane_cfg | a0 a1 a2 a3 | b0 b1 b2 b3 | expected r0 r1 r2 r3
// all fields hex, registers zero-extended to 128 bits
1 0 0 0  80ff7f01 0 0 0  03018102 0 0 0  83000003 0 0 0
2 0 0 0  80ff7f01 0 0 0  03018102 0 0 0  7dfefeff 0 0 0
3 0 0 0  80ff7f01 0 0 0  03018102 0 0 0  00010100 0 0 0
4 0 0 0  80ff7f01 0 0 0  03018102 0 0 0  83ffff03 0 0 0
5 0 0 0  80ff7f01 0 0 0  03018102 0 0 0  83fefe03 0 0 0
6 0 0 0  80ff7f01 0 0 0  03018102 0 0 0  00fefe04 0 0 0
7 0 0 0  80ff7f01 0 0 0  03018102 0 0 0  107f3f00 0 0 0
8 0 0 0  80ff7f01 0 0 0  03018102 0 0 0  f0ff3f00 0 0 0
9 0 0 0  80ff7f01 0 0 0  03018102 0 0 0  80ff8101 0 0 0
a 0 0 0  80ff7f01 0 0 0  03018102 0 0 0  03017f02 0 0 0
b 0 0 0  80ff7f01 0 0 0  03018102 0 0 0  03017f01 0 0 0
c 0 0 0  80ff7f01 0 0 0  03018102 0 0 0  80ff8102 0 0 0
1 1 0 0  80ff7f01 0 0 0  03018102 0 0 0  84000003 0 0 0
8 1 0 0  80ff7f01 0 0 0  03018102 0 0 0  c07f1fc0 0 0 0
9 1 0 0  80ff7f01 0 0 0  03018102 0 0 0  80ff8102 0 0 0
6 1 0 0  80ff7f01 0 0 0  03018102 0 0 0  01fefc04 0 0 0
1 2 0 0  80ff7f01 0 0 0  03018102 0 0 0  84010003 0 0 0
2 2 0 0  80ff7f01 0 0 0  03018102 0 0 0  7dfdfdff 0 0 0
8 2 0 0  80ff7f01 0 0 0  03018102 0 0 0  e03fdfc0 0 0 0
b 2 0 0  80ff7f01 0 0 0  03018102 0 0 0  03018102 0 0 0
1 2 1 0  1 2 3 4  10 20 30 40  11 22 0 0
1 2 1 1  1 2 3 4  10 20 30 40  11 22 0 0
1 2 2 0  1 2 3 4  10 20 30 40  11 22 33 44
1 2 2 1  1 2 3 4  10 20 30 40  11 22 33 44
1 2 2 2  1 2 3 4  10 20 30 40  11 22 33 44

/* valu_top.sv */
`timescale 1ns/1ps

module valu_top (
    input  logic                      valu_clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  valu_op_pkg::alu_op_e      op,
    input  valu_op_pkg::sew_e         sew,
    input  valu_op_pkg::lmul_e        lmul,
    input  valu_op_pkg::lane_cfg_e    lane_cfg,
    input  valu_cfg_pkg::vreg_group_t op_a,
    input  valu_cfg_pkg::vreg_group_t op_b,
    output valu_cfg_pkg::vreg_group_t result,
    output logic                      busy,
    output logic                      done
);
    import valu_cfg_pkg::*;
    import valu_op_pkg::*;

    // captured command
    alu_op_e     cmd_op;
    sew_e        cmd_sew;
    lmul_e       cmd_lmul;
    lane_cfg_e   cmd_lane_cfg;
    vreg_group_t cmd_a;
    vreg_group_t cmd_b;

    logic [pass_w-1:0] pass_idx;
    logic              pass_valid;
    logic              clear;
    logic              finish;

    // per lane group
    vreg_t    [max_groups-1:0] grp_a;
    vreg_t    [max_groups-1:0] grp_b;
    vreg_t    [max_groups-1:0] grp_y;
    logic     [max_groups-1:0] grp_en;
    reg_idx_t [max_groups-1:0] grp_reg;

    valu_sequencer u_seq (
        .valu_clk     (valu_clk),
        .rst_n        (rst_n),
        .start        (start),
        .op           (op),
        .sew          (sew),
        .lmul         (lmul),
        .lane_cfg     (lane_cfg),
        .op_a         (op_a),
        .op_b         (op_b),
        .cmd_op       (cmd_op),
        .cmd_sew      (cmd_sew),
        .cmd_lmul     (cmd_lmul),
        .cmd_lane_cfg (cmd_lane_cfg),
        .cmd_a        (cmd_a),
        .cmd_b        (cmd_b),
        .pass_idx     (pass_idx),
        .pass_valid   (pass_valid),
        .clear        (clear),
        .finish       (finish),
        .busy         (busy)
    );

    valu_operand_router u_router (
        .pass_idx  (pass_idx),
        .group_cnt (cmd_lane_cfg),
        .reg_cnt   (cmd_lmul),
        .op_a      (cmd_a),
        .op_b      (cmd_b),
        .grp_a     (grp_a),
        .grp_b     (grp_b),
        .grp_en    (grp_en),
        .grp_reg   (grp_reg)
    );

    //////////////////////////////////////////////////////////////////////
    // four groups of four 32-bit lanes
    for (genvar g = 0; g < max_groups; g++) begin : g_grp
        for (genvar l = 0; l < lanes_per_group; l++) begin : g_lane
            valu_lane u_lane (
                .op  (cmd_op),
                .sew (cmd_sew),
                .a   (grp_a[g][l*elen +: elen]),
                .b   (grp_b[g][l*elen +: elen]),
                .y   (grp_y[g][l*elen +: elen])
            );
        end
    end

    valu_result_buffer u_rbuf (
        .valu_clk   (valu_clk),
        .rst_n      (rst_n),
        .clear      (clear),
        .finish     (finish),
        .pass_valid (pass_valid),
        .grp_y      (grp_y),
        .grp_en     (grp_en),
        .grp_reg    (grp_reg),
        .result     (result),
        .done       (done)
    );

endmodule
